// File: tests/ex_ref.svh
`ifndef EX_REF_SVH
`define EX_REF_SVH

function automatic logic is_csr_inst(input logic [31:0] inst);
    return (inst[6:0] == ex_pkg::OPC_SYSTEM) && (inst[13:12] != 2'b00);
endfunction

function automatic logic [31:0] alu_result(input ex_pkg::ex_req_t r);
    logic [31:0] b;
    b = (r.inst[6:0] == ex_pkg::OPC_OP_IMM) ? r.imm : r.rs2_data;
    case (r.inst[14:12])
        3'd0:    return r.rs1_data + b;
        3'd1:    return r.rs1_data << b[4:0];
        3'd2:    return ($signed(r.rs1_data) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (r.rs1_data < b) ? 32'd1 : 32'd0;
        3'd4:    return r.rs1_data ^ b;
        3'd5:    return r.rs1_data >> b[4:0];  // logical only
        3'd6:    return r.rs1_data | b;
        default: return r.rs1_data & b;
    endcase
endfunction

function automatic logic branch_holds(input ex_pkg::ex_req_t r);
    logic signed [31:0] a;
    logic signed [31:0] b;
    a = r.rs1_data;
    b = r.rs2_data;
    case (r.inst[14:12])
        ex_pkg::F3_BEQ:  return r.rs1_data == r.rs2_data;
        ex_pkg::F3_BNE:  return r.rs1_data != r.rs2_data;
        ex_pkg::F3_BLT:  return a < b;
        ex_pkg::F3_BGE:  return a >= b;
        ex_pkg::F3_BLTU: return r.rs1_data < r.rs2_data;
        ex_pkg::F3_BGEU: return r.rs1_data >= r.rs2_data;
        default:         return 1'b0;
    endcase
endfunction

function automatic ex_pkg::reg_wb_t reg_wb_model(input ex_pkg::ex_req_t r);
    ex_pkg::reg_wb_t wb;
    logic            writes;
    wb.addr = r.inst[11:7];
    wb.data = '0;
    writes  = 1'b1;
    case (r.inst[6:0])
        ex_pkg::OPC_OP_IMM: wb.data = alu_result(r);
        ex_pkg::OPC_OP: begin
            wb.data = alu_result(r);
            writes  = (r.inst[31:25] == 7'd0);  // sub and sra are not handled
        end
        ex_pkg::OPC_LUI:   wb.data = r.imm;
        ex_pkg::OPC_AUIPC: wb.data = r.pc + r.imm;
        ex_pkg::OPC_JAL,
        ex_pkg::OPC_JALR:  wb.data = r.pc + 32'd4;
        ex_pkg::OPC_SYSTEM: begin
            wb.data = r.csr_rdata;  // old csr value
            writes  = is_csr_inst(r.inst);
        end
        default: writes = 1'b0;
    endcase
    wb.valid = r.valid && writes && (wb.addr != 5'd0);
    return wb;
endfunction

function automatic ex_pkg::csr_wb_t csr_wb_model(input ex_pkg::ex_req_t r);
    ex_pkg::csr_wb_t wb;
    logic [31:0]     src;
    src      = r.inst[14] ? {27'd0, r.inst[19:15]} : r.rs1_data;
    wb.valid = r.valid && is_csr_inst(r.inst);
    wb.addr  = r.inst[31:20];
    case (r.inst[13:12])
        2'b01:   wb.data = src;
        2'b10:   wb.data = r.csr_rdata | src;
        default: wb.data = r.csr_rdata & ~src;
    endcase
    return wb;
endfunction

function automatic ex_pkg::redirect_t redirect_model(input ex_pkg::ex_req_t r);
    ex_pkg::redirect_t red;
    logic [31:0]       sum;
    sum        = r.rs1_data + r.imm;
    red.valid  = 1'b0;
    red.target = r.pc + r.imm;
    case (r.inst[6:0])
        ex_pkg::OPC_JAL: red.valid = 1'b1;
        ex_pkg::OPC_JALR: begin
            red.valid  = 1'b1;
            red.target = sum & ~32'd1;
        end
        ex_pkg::OPC_BRANCH: red.valid = branch_holds(r);
        default:            red.valid = 1'b0;
    endcase
    red.valid = red.valid && r.valid;
    return red;
endfunction

`endif

// File: tests/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;

    `include "ex_ref.svh"

    logic              clk;
    logic              rst_n_i;
    ex_pkg::ex_req_t   req;
    ex_pkg::reg_wb_t   reg_wb_o;
    ex_pkg::csr_wb_t   csr_wb_o;
    ex_pkg::redirect_t redirect_o;

    ex_pkg::ex_req_t   prev_req;
    logic              prev_rst_n = 1'b0;
    logic              primed = 1'b0;
    ex_pkg::reg_wb_t   exp_reg;
    ex_pkg::csr_wb_t   exp_csr;
    ex_pkg::redirect_t exp_redir;
    int                error_count = 0;
    int                check_count = 0;
    int                tests_run = 0;

    ex_top uut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req),
        .reg_wb_o   (reg_wb_o),
        .csr_wb_o   (csr_wb_o),
        .redirect_o (redirect_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n_i = 1'b0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
    end

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // outputs seen at this edge belong to the request sampled at the previous one
    always @(posedge clk) begin
        if (primed) begin
            exp_reg   = reg_wb_model(prev_req);
            exp_csr   = csr_wb_model(prev_req);
            exp_redir = redirect_model(prev_req);
            if (!prev_rst_n) begin
                exp_reg.valid   = 1'b0;
                exp_csr.valid   = 1'b0;
                exp_redir.valid = 1'b0;
            end
            check_field("reg_wb_o.valid", exp_reg.valid, reg_wb_o.valid);
            if (exp_reg.valid) begin
                check_field("reg_wb_o.addr", exp_reg.addr, reg_wb_o.addr);
                check_field("reg_wb_o.data", exp_reg.data, reg_wb_o.data);
            end
            check_field("csr_wb_o.valid", exp_csr.valid, csr_wb_o.valid);
            if (exp_csr.valid) begin
                check_field("csr_wb_o.addr", exp_csr.addr, csr_wb_o.addr);
                check_field("csr_wb_o.data", exp_csr.data, csr_wb_o.data);
            end
            check_field("redirect_o.valid", exp_redir.valid, redirect_o.valid);
            if (exp_redir.valid) begin
                check_field("redirect_o.target", exp_redir.target, redirect_o.target);
            end
        end
        primed     <= 1'b1;
        prev_req   <= req;
        prev_rst_n <= rst_n_i;
    end

    // kinds: 0 op, 1 op-imm, 2 branch, 3 jal, 4 jalr, 5 lui, 6 auipc, 7 csr,
    // 8 valid low, 9 unsupported
    function automatic ex_pkg::ex_req_t pick_req(input int kind);
        ex_pkg::ex_req_t r;
        logic [2:0]      f3;
        r.valid     = 1'b1;
        r.inst      = $urandom;
        r.pc        = $urandom & 32'hffff_fffc;
        r.rs1_data  = $urandom;
        r.rs2_data  = $urandom;
        r.imm       = $urandom;
        r.csr_rdata = $urandom;
        f3          = 3'($urandom % 8);
        case (kind)
            0: begin
                r.inst[6:0]   = ex_pkg::OPC_OP;
                r.inst[31:25] = 7'd0;
            end
            1, 8: begin
                r.inst[6:0] = ex_pkg::OPC_OP_IMM;
                if (r.inst[13:12] == 2'b01) begin
                    r.inst[31:25] = 7'd0;  // slli/srli encoding
                end
                r.imm   = {{20{r.inst[31]}}, r.inst[31:20]};
                r.valid = (kind != 8);
            end
            2: begin
                r.inst[6:0] = ex_pkg::OPC_BRANCH;
                f3          = 3'($urandom % 6);
                r.inst[14:12] = (f3 > 3'd1) ? f3 + 3'd2 : f3;
                r.imm       = r.imm & ~32'd1;
                if ($urandom % 2) begin
                    r.rs2_data = r.rs1_data;
                end
            end
            3: begin
                r.inst[6:0] = ex_pkg::OPC_JAL;
                r.imm       = r.imm & ~32'd1;
            end
            4: begin
                r.inst[6:0]   = ex_pkg::OPC_JALR;
                r.inst[14:12] = 3'd0;
                r.imm         = {{20{r.imm[11]}}, r.imm[11:0]};  // odd sums too
            end
            5: begin
                r.inst[6:0] = ex_pkg::OPC_LUI;
                r.imm       = r.imm & 32'hffff_f000;
            end
            6: begin
                r.inst[6:0] = ex_pkg::OPC_AUIPC;
                r.imm       = r.imm & 32'hffff_f000;
            end
            7: begin
                r.inst[6:0]   = ex_pkg::OPC_SYSTEM;
                f3            = 3'($urandom % 6);
                r.inst[14:12] = (f3 > 3'd2) ? f3 + 3'd2 : f3 + 3'd1;
            end
            default: begin
                case ($urandom % 6)
                    0: r.inst[6:0] = 7'b0000011;  // load
                    1: r.inst[6:0] = 7'b0100011;  // store
                    2: r.inst[6:0] = 7'b0001111;  // fence
                    3: r.inst[6:0] = 7'b1111111;
                    4: begin
                        r.inst[6:0]   = ex_pkg::OPC_OP;
                        r.inst[31:25] = 7'b0100000;  // sub
                    end
                    default: begin
                        r.inst[6:0]   = ex_pkg::OPC_SYSTEM;
                        r.inst[14:12] = 3'd0;  // ecall
                    end
                endcase
            end
        endcase
        return r;
    endfunction

    task automatic send(input ex_pkg::ex_req_t r);
        @(posedge clk);
        req <= r;
    endtask

    task automatic send_mix(input int lo, input int hi, input int count);
        repeat (count) send(pick_req(lo + int'($urandom % (hi - lo + 1))));
    endtask

    // last result is checked one edge after the idle request goes in
    task automatic drain;
        send('0);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        $display("test %-8s %s, %0d errors", name,
                 (error_count == errs_before) ? "done" : "failed", error_count - errs_before);
    endtask

    task automatic run_tests;
        ex_pkg::ex_req_t r;
        int              errs;
        errs = error_count;
        send_mix(0, 1, 60);
        r = pick_req(0);
        r.inst[14:12] = ex_pkg::F3_XOR;
        r.inst[11:7]  = 5'd5;
        r.rs1_data    = 32'hff00_ff00;
        r.rs2_data    = 32'h0ff0_0ff0;
        send(r);
        r = pick_req(1);
        r.inst[11:7] = 5'd0;
        send(r);
        drain();
        close_test("alu", errs);

        errs = error_count;
        send_mix(2, 2, 60);
        drain();
        close_test("branch", errs);

        errs = error_count;
        send_mix(3, 6, 40);
        drain();
        close_test("jump", errs);

        errs = error_count;
        send_mix(7, 7, 40);
        drain();
        close_test("csr", errs);

        errs = error_count;
        send_mix(0, 9, 120);
        drain();
        close_test("mixed", errs);
    endtask

    initial begin
        ex_pkg::ex_req_t r;
        void'($urandom(32'hb8c8));
        r = pick_req(1);
        r.inst[11:7] = 5'd1;  // valid request held through reset
        req = r;

        for (int i = 0; i < 20 && !rst_n_i; i++) begin
            @(posedge clk);
        end
        if (!rst_n_i) begin
            $display("reset was not released within 20 cycles");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            @(negedge clk);
            close_test("reset", 0);
            run_tests();
            $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
            if (error_count == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+tests
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_csr.sv
verilog/ex_result_reg.sv
verilog/ex_top.sv
tests/ex_tb.sv

// File: verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::op_class_e       op_class_i,
    input  ex_pkg::alu_op_e         alu_op_i,
    input  logic                    imm_sel_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_data_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    logic [ex_pkg::XLEN-1:0]    op_b;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic [ex_pkg::XLEN-1:0]    alu_res;
    logic                       lt;
    logic                       ltu;

    assign op_b  = imm_sel_i ? imm_i : rs2_data_i;
    assign shamt = op_b[ex_pkg::SHAMT_W-1:0];

    assign lt  = $signed(rs1_data_i) < $signed(op_b);
    assign ltu = rs1_data_i < op_b;

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:  alu_res = rs1_data_i + op_b;
            ex_pkg::ALU_SLT:  alu_res = {{(ex_pkg::XLEN-1){1'b0}}, lt};
            ex_pkg::ALU_SLTU: alu_res = {{(ex_pkg::XLEN-1){1'b0}}, ltu};
            ex_pkg::ALU_XOR:  alu_res = rs1_data_i ^ op_b;
            ex_pkg::ALU_OR:   alu_res = rs1_data_i | op_b;
            ex_pkg::ALU_AND:  alu_res = rs1_data_i & op_b;
            ex_pkg::ALU_SLL:  alu_res = rs1_data_i << shamt;
            ex_pkg::ALU_SRL:  alu_res = rs1_data_i >> shamt;
            default:          alu_res = '0;
        endcase
    end

    always_comb begin
        case (op_class_i)
            ex_pkg::CLS_ALU:   result_o = alu_res;
            ex_pkg::CLS_LUI:   result_o = imm_i;        // imm holds the upper 20 bits
            ex_pkg::CLS_AUIPC: result_o = pc_i + imm_i;
            ex_pkg::CLS_JAL,
            ex_pkg::CLS_JALR:  result_o = pc_i + 32'd4; // link value
            default:           result_o = '0;
        endcase
    end

endmodule

// File: verilog/ex_branch.sv
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::op_class_e       op_class_i,
    input  logic [2:0]              funct3_i,
    input  logic [ex_pkg::XLEN-1:0] rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_data_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic [ex_pkg::XLEN-1:0] pc_i,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);

    logic                    eq;
    logic                    lt;
    logic                    ltu;
    logic                    cond;
    logic [ex_pkg::XLEN-1:0] jalr_sum;

    assign eq  = rs1_data_i == rs2_data_i;
    assign lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign ltu = rs1_data_i < rs2_data_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::F3_BEQ:  cond = eq;
            ex_pkg::F3_BNE:  cond = ~eq;
            ex_pkg::F3_BLT:  cond = lt;
            ex_pkg::F3_BGE:  cond = ~lt;
            ex_pkg::F3_BLTU: cond = ltu;
            ex_pkg::F3_BGEU: cond = ~ltu;
            default:         cond = 1'b0;  // 010/011 never branch
        endcase
    end

    always_comb begin
        case (op_class_i)
            ex_pkg::CLS_BRANCH: taken_o = cond;
            ex_pkg::CLS_JAL,
            ex_pkg::CLS_JALR:   taken_o = 1'b1;
            default:            taken_o = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign jalr_sum = rs1_data_i + imm_i;
    assign target_o = (op_class_i == ex_pkg::CLS_JALR) ? {jalr_sum[ex_pkg::XLEN-1:1], 1'b0}
                                                       : pc_i + imm_i;

endmodule

// File: verilog/ex_csr.sv
`timescale 1ns/1ps

module ex_csr (
    input  logic [2:0]                    funct3_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] uimm_i,
    input  logic [ex_pkg::XLEN-1:0]       csr_rdata_i,
    output logic [ex_pkg::XLEN-1:0]       csr_wdata_o
);

    logic [ex_pkg::XLEN-1:0] operand;

    // immediate forms use the zero-extended rs1 field
    assign operand = funct3_i[2] ? {{(ex_pkg::XLEN-ex_pkg::REG_ADDR_W){1'b0}}, uimm_i}
                                 : rs1_data_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::F3_CSRRW,
            ex_pkg::F3_CSRRWI: begin
                csr_wdata_o = operand;
            end
            ex_pkg::F3_CSRRS,
            ex_pkg::F3_CSRRSI: begin
                csr_wdata_o = csr_rdata_i | operand;   // set bits
            end
            ex_pkg::F3_CSRRC,
            ex_pkg::F3_CSRRCI: begin
                csr_wdata_o = csr_rdata_i & ~operand;  // clear bits
            end
            default: begin
                csr_wdata_o = csr_rdata_i;
            end
        endcase
    end

endmodule

// File: verilog/ex_decode.sv
`timescale 1ns/1ps

module ex_decode (
    input  logic [ex_pkg::XLEN-1:0]       inst_i,
    output ex_pkg::op_class_e             op_class_o,
    output ex_pkg::alu_op_e               alu_op_o,
    output logic                          imm_sel_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [2:0]                    funct3_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] uimm_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode     = inst_i[6:0];
    assign funct7     = inst_i[31:25];
    assign funct3_o   = inst_i[14:12];
    assign rd_o       = inst_i[11:7];
    assign uimm_o     = inst_i[19:15];  // rs1 field
    assign csr_addr_o = inst_i[31:20];

    always_comb begin
        case (funct3_o)
            ex_pkg::F3_ADD:  alu_op_o = ex_pkg::ALU_ADD;
            ex_pkg::F3_SLL:  alu_op_o = ex_pkg::ALU_SLL;
            ex_pkg::F3_SLT:  alu_op_o = ex_pkg::ALU_SLT;
            ex_pkg::F3_SLTU: alu_op_o = ex_pkg::ALU_SLTU;
            ex_pkg::F3_XOR:  alu_op_o = ex_pkg::ALU_XOR;
            ex_pkg::F3_SRL:  alu_op_o = ex_pkg::ALU_SRL;
            ex_pkg::F3_OR:   alu_op_o = ex_pkg::ALU_OR;
            default:         alu_op_o = ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        imm_sel_o  = 1'b0;
        op_class_o = ex_pkg::CLS_NONE;
        case (opcode)
            ex_pkg::OPC_OP_IMM: begin
                op_class_o = ex_pkg::CLS_ALU;
                imm_sel_o  = 1'b1;
            end
            ex_pkg::OPC_OP: begin
                // no sub, no sra
                if (funct7 == ex_pkg::F7_BASE) begin
                    op_class_o = ex_pkg::CLS_ALU;
                end
            end
            ex_pkg::OPC_BRANCH: op_class_o = ex_pkg::CLS_BRANCH;
            ex_pkg::OPC_JAL:    op_class_o = ex_pkg::CLS_JAL;
            ex_pkg::OPC_JALR:   op_class_o = ex_pkg::CLS_JALR;
            ex_pkg::OPC_LUI:    op_class_o = ex_pkg::CLS_LUI;
            ex_pkg::OPC_AUIPC:  op_class_o = ex_pkg::CLS_AUIPC;
            ex_pkg::OPC_SYSTEM: begin
                if (funct3_o[1:0] != 2'b00) begin  // ecall/ebreak excluded
                    op_class_o = ex_pkg::CLS_CSR;
                end
            end
            default: op_class_o = ex_pkg::CLS_NONE;
        endcase
    end

endmodule

// File: verilog/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int SHAMT_W    = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;

    // alu group, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // bit 2 selects the uimm forms
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_CSR
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;       // already extracted by decode
        logic [XLEN-1:0] csr_rdata;
    } ex_req_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

// File: verilog/ex_result_reg.sv
`timescale 1ns/1ps

module ex_result_reg #(
    parameter type payload_t = ex_pkg::redirect_t
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // payload follows d_i every edge, only valid is cleared
    always_ff @(posedge clk) begin
        q_o <= d_i;
        if (!rst_n_i) begin
            q_o.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/ex_top.sv
`timescale 1ns/1ps

module ex_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ex_pkg::ex_req_t   req_i,
    output ex_pkg::reg_wb_t   reg_wb_o,
    output ex_pkg::csr_wb_t   csr_wb_o,
    output ex_pkg::redirect_t redirect_o
);

    ex_pkg::op_class_e             op_class;
    ex_pkg::alu_op_e               alu_op;
    logic                          imm_sel;
    logic [ex_pkg::REG_ADDR_W-1:0] rd;
    logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr;
    logic [2:0]                    funct3;
    logic [ex_pkg::REG_ADDR_W-1:0] uimm;
    logic [ex_pkg::XLEN-1:0]       alu_result;
    logic                          br_taken;
    logic [ex_pkg::XLEN-1:0]       br_target;
    logic [ex_pkg::XLEN-1:0]       csr_wdata;
    logic                          writes_rd;
    ex_pkg::reg_wb_t               reg_wb_d;
    ex_pkg::csr_wb_t               csr_wb_d;
    ex_pkg::redirect_t             redirect_d;

    ex_decode u_decode (
        .inst_i     (req_i.inst),
        .op_class_o (op_class),
        .alu_op_o   (alu_op),
        .imm_sel_o  (imm_sel),
        .rd_o       (rd),
        .csr_addr_o (csr_addr),
        .funct3_o   (funct3),
        .uimm_o     (uimm)
    );

    ex_alu u_alu (
        .op_class_i (op_class),
        .alu_op_i   (alu_op),
        .imm_sel_i  (imm_sel),
        .rs1_data_i (req_i.rs1_data),
        .rs2_data_i (req_i.rs2_data),
        .imm_i      (req_i.imm),
        .pc_i       (req_i.pc),
        .result_o   (alu_result)
    );

    ex_branch u_branch (
        .op_class_i (op_class),
        .funct3_i   (funct3),
        .rs1_data_i (req_i.rs1_data),
        .rs2_data_i (req_i.rs2_data),
        .imm_i      (req_i.imm),
        .pc_i       (req_i.pc),
        .taken_o    (br_taken),
        .target_o   (br_target)
    );

    ex_csr u_csr (
        .funct3_i    (funct3),
        .rs1_data_i  (req_i.rs1_data),
        .uimm_i      (uimm),
        .csr_rdata_i (req_i.csr_rdata),
        .csr_wdata_o (csr_wdata)
    );

    always_comb begin
        case (op_class)
            ex_pkg::CLS_ALU,
            ex_pkg::CLS_LUI,
            ex_pkg::CLS_AUIPC,
            ex_pkg::CLS_JAL,
            ex_pkg::CLS_JALR,
            ex_pkg::CLS_CSR: writes_rd = 1'b1;
            default:         writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        reg_wb_d.valid = req_i.valid & writes_rd & (rd != '0);  // x0 stays zero
        reg_wb_d.addr  = rd;
        reg_wb_d.data  = (op_class == ex_pkg::CLS_CSR) ? req_i.csr_rdata : alu_result;

        csr_wb_d.valid = req_i.valid & (op_class == ex_pkg::CLS_CSR);
        csr_wb_d.addr  = csr_addr;
        csr_wb_d.data  = csr_wdata;

        redirect_d.valid  = req_i.valid & br_taken;
        redirect_d.target = br_target;
    end

    ex_result_reg #(.payload_t(ex_pkg::reg_wb_t)) u_reg_wb_q (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (reg_wb_d),
        .q_o     (reg_wb_o)
    );

    ex_result_reg #(.payload_t(ex_pkg::csr_wb_t)) u_csr_wb_q (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (csr_wb_d),
        .q_o     (csr_wb_o)
    );

    ex_result_reg #(.payload_t(ex_pkg::redirect_t)) u_redirect_q (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .d_i     (redirect_d),
        .q_o     (redirect_o)
    );

endmodule
